//--- flist.f
design/colmix_pkg.sv
design/pal_ram.sv
design/pal_apb.sv
design/colmix_pixel.sv
design/blank_delay.sv
design/colmix_top.sv
bench/clk_gen.sv
bench/colmix_tb.sv

//--- Makefile
# Verilator build and run of the colour mixer testbench

TOP := colmix_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- bench/colmix_tb.sv
/*
 * Colour mixer testbench
 * Fills the palette over APB, checks read-back with byte strobes, then
 * walks a pixel table through the layer, shadow, video-enable and
 * blanking rules against a reference palette model
 */
`timescale 1ns/1ps

module colmix_tb;
    import colmix_pkg::*;

    localparam int APB_TMO = 8;    // Clocks allowed for pready
    localparam int RST_TMO = 20;
    localparam int NROWS   = 15;

    // Pixel stimulus followed by the expected blanking outputs
    typedef struct packed {
        layer_t     rc;
        logic [7:0] rd_pxl;
        pal_addr_t  tmap;
        logic       shadow;
        logic       ven;
        logic       hb;
        logic       vb;
        logic       exp_h;
        logic       exp_v;
    } row_t;

    logic     clk, rst;
    logic     pxl_cen, video_en, pre_lhbl, pre_lvbl;
    logic     lhbl, lvbl;
    pxl_in_t  pix;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;
    rgb_t     rgb;

    pal_word_t   model [0:(1<<PAL_AW)-1];  // Reference copy of the palette
    logic [31:0] lcg_state = 32'hb64181ac;

    //             rc     rd_pxl  tmap     sh    ven   hb    vb    exp_h exp_v
    row_t rows [NROWS] = '{
        '{2'd0, 8'h05, 11'h000, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // Layer 0
        '{2'd1, 8'h3a, 11'h000, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
        '{2'd2, 8'h17, 11'h000, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // rd_pxl[4] set
        '{2'd2, 8'h2c, 11'h000, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
        '{2'd3, 8'h3f, 11'h5a3, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // Tile map
        '{2'd3, 8'h00, 11'h7ff, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
        '{2'd3, 8'h00, 11'h100, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // Dimmed
        '{2'd3, 8'h00, 11'h101, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},  // Protected
        '{2'd2, 8'h0e, 11'h000, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1},
        '{2'd0, 8'h09, 11'h000, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},  // Video off
        '{2'd3, 8'h00, 11'h100, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1},
        '{2'd1, 8'h21, 11'h000, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1},  // H blank
        '{2'd1, 8'h21, 11'h000, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0},  // V blank
        '{2'd3, 8'h00, 11'h2c4, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0},
        '{2'd3, 8'h00, 11'h101, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1}
    };

    clk_gen u_clk (.clk(clk), .rst(rst));

    colmix_top dut0 (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .video_en(video_en),
        .pre_lhbl(pre_lhbl), .pre_lvbl(pre_lvbl), .pix(pix),
        .apb_req(apb_req), .apb_rsp(apb_rsp), .rgb(rgb), .lhbl(lhbl), .lvbl(lvbl)
    );

    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(negedge clk);
            pxl_cen = ~pxl_cen;  // Every other clock
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Palette address from the layer rule
    function automatic pal_addr_t pal_index(input layer_t rc, input logic [7:0] rd,
                                            input pal_addr_t tmap);
        pal_addr_t a;
        if (rc == 2'd3) return tmap;  // Tile map takes the whole address
        a[3:0]  = rd[3:0];
        a[5:4]  = (rc[1] == 1'b0) ? 2'b11 : {1'b0, rd[4]};
        a[10:6] = rc[1] ? 5'h1f : 5'h00;
        return a;
    endfunction

    function automatic rgb_t expect_rgb(input row_t r);
        pal_word_t w;
        rgb_t      c;
        w       = model[pal_index(r.rc, r.rd_pxl, r.tmap)];
        c.red   = {w[3:0], w[12]};
        c.green = {w[7:4], w[13]};
        c.blue  = {w[11:8], w[14]};
        if (r.shadow && !w[15]) begin  // Three quarters brightness
            c.red   = c.red - (c.red >> 2);
            c.green = c.green - (c.green >> 2);
            c.blue  = c.blue - (c.blue >> 2);
        end
        if (!r.ven || !r.hb || !r.vb) c = '0;
        return c;
    endfunction

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input pal_word_t got, input pal_word_t exp);
        if (got !== exp)
            fail_stop($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp)
            fail_stop($sformatf("FAIL t=%0t %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_stop($sformatf("FAIL t=%0t %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        while (rst) begin
            @(negedge clk);
            n++;
            if (n > RST_TMO) fail_stop("reset was never released");
        end
    endtask

    // Counts pxl_cen pulses and returns on a falling edge
    task automatic wait_cen(input int count);
        int seen, cycles;
        seen   = 0;
        cycles = 0;
        while (seen < count) begin
            @(posedge clk);
            if (pxl_cen) seen++;
            cycles++;
            if (cycles > 4 * count + 8) fail_stop("pixel enable stopped toggling");
        end
        @(negedge clk);
    endtask

    // One APB transfer that starts and ends on a falling edge
    task automatic apb_xfer(input logic wr, input pal_addr_t addr, input pal_word_t wdata,
                            input logic [1:0] strb, output pal_word_t rdata);
        logic done;
        apb_req.psel    = 1'b1;  // Setup phase
        apb_req.penable = 1'b0;
        apb_req.pwrite  = wr;
        apb_req.paddr   = {addr, 1'b0};
        apb_req.pwdata  = wdata;
        apb_req.pstrb   = wr ? strb : 2'b00;
        @(negedge clk);
        apb_req.penable = 1'b1;
        done  = 1'b0;
        rdata = '0;
        for (int n = 0; n < APB_TMO && !done; n++) begin
            #5;  // Mid low phase with the request settled
            if (apb_rsp.pready) begin
                done  = 1'b1;
                rdata = apb_rsp.prdata;
            end
            @(negedge clk);
        end
        apb_req = '0;
        if (!done) fail_stop("APB transfer never got pready");
    endtask

    task automatic pal_write(input pal_addr_t addr, input pal_word_t w, input logic [1:0] strb);
        pal_word_t unused;
        apb_xfer(1'b1, addr, w, strb, unused);
        if (strb[0]) model[addr][7:0] = w[7:0];
        if (strb[1]) model[addr][15:8] = w[15:8];
    endtask

    task automatic pal_read(input pal_addr_t addr, output pal_word_t w);
        apb_xfer(1'b0, addr, '0, 2'b00, w);
    endtask

    task automatic apply_row(input row_t r);
        pix.rc        = r.rc;
        pix.rd_pxl    = r.rd_pxl;
        pix.tmap_addr = r.tmap;
        pix.shadow    = r.shadow;
        video_en      = r.ven;
        pre_lhbl      = r.hb;
        pre_lvbl      = r.vb;
    endtask

    // Rewrites the entry on screen and expects the new colour
    task automatic live_update();
        row_t r;
        r = '{2'd3, 8'h00, 11'h3c0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 1'b1};
        apply_row(r);
        wait_cen(8);
        check_rgb("rgb before update", rgb, expect_rgb(r));
        pal_write(11'h3c0, ~model[11'h3c0], 2'b11);  // Every colour bit flips
        wait_cen(8);
        check_rgb("rgb after update", rgb, expect_rgb(r));
        pal_write(11'h3c0, ~model[11'h3c0], 2'b10);  // High byte only
        wait_cen(8);
        check_rgb("rgb after byte update", rgb, expect_rgb(r));
    endtask

    initial begin
        pal_word_t  rd;
        pal_addr_t  a;
        pal_word_t  w;
        logic [1:0] strb;
        video_en = 1'b0;
        pre_lhbl = 1'b0;
        pre_lvbl = 1'b0;
        pix      = '0;
        apb_req  = '0;
        wait_reset();
        check_bit("pready", apb_rsp.pready, 1'b0);  // Idle bus
        check_rgb("rgb", rgb, '0);
        check_bit("lhbl", lhbl, 1'b0);
        check_bit("lvbl", lvbl, 1'b0);

        for (int i = 0; i < (1 << PAL_AW); i++) begin  // Whole palette
            lcg_state = lcg_next(lcg_state);
            pal_write(pal_addr_t'(i), lcg_state[31:16], 2'b11);
        end

        // Random write and read-back with some single strobes
        for (int i = 0; i < 24; i++) begin
            lcg_state = lcg_next(lcg_state);
            a         = lcg_state[26:16];
            lcg_state = lcg_next(lcg_state);
            w         = lcg_state[31:16];
            strb      = (i % 3 == 0) ? 2'b01 : (i % 3 == 1) ? 2'b10 : 2'b11;
            pal_write(a, w, strb);
            pal_read(a, rd);
            check_word("prdata", rd, model[a]);
        end

        pal_write(11'h100, 16'h4abc, 2'b11);  // Bit 15 clear
        pal_write(11'h101, 16'hcabc, 2'b11);  // Same colour, protected

        for (int i = 0; i < NROWS; i++) begin
            apply_row(rows[i]);
            wait_cen(8);
            check_rgb("rgb", rgb, expect_rgb(rows[i]));
            check_bit("lhbl", lhbl, rows[i].exp_h);
            check_bit("lvbl", lvbl, rows[i].exp_v);
        end

        live_update();

        $display("TEST PASS");
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
/*
 * Testbench clock and reset
 * 20 ns clock, synchronous reset held high for the first four cycles
 */
`timescale 1ns/1ps

module clk_gen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;  // Dropped on a rising edge, seen low at the next falling one
    end

endmodule

//--- design/colmix_top.sv
/*
 * Colour mixer top level
 * APB palette access, palette RAM, pixel colour stage and blanking
 * delay for the tile-and-sprite video board
 */
`timescale 1ns/1ps

module colmix_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 pxl_cen,
    input  logic                 video_en,
    input  logic                 pre_lhbl,
    input  logic                 pre_lvbl,
    input  colmix_pkg::pxl_in_t  pix,
    input  colmix_pkg::apb_req_t apb_req,
    output colmix_pkg::apb_rsp_t apb_rsp,
    output colmix_pkg::rgb_t     rgb,
    output logic                 lhbl,
    output logic                 lvbl
);
    import colmix_pkg::*;

    pal_addr_t  cpu_addr;
    pal_word_t  cpu_wdata;
    logic [1:0] cpu_we;
    pal_word_t  cpu_rdata;
    pal_addr_t  vid_addr;
    pal_word_t  vid_rdata;
    rgb_t       rgb_gated;   // Colour before the blanking delay

    pal_apb u_apb (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata)
    );

    pal_ram u_ram (
        .clk       (clk),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_we    (cpu_we),
        .cpu_rdata (cpu_rdata),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_rdata)
    );

    colmix_pixel u_pixel (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .video_en  (video_en),
        .pix       (pix),
        .vid_addr  (vid_addr),
        .vid_rdata (vid_rdata),
        .rgb_gated (rgb_gated)
    );

    blank_delay u_blank (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .pre_lhbl  (pre_lhbl),
        .pre_lvbl  (pre_lvbl),
        .rgb_in    (rgb_gated),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .rgb       (rgb)
    );

endmodule

//--- design/blank_delay.sv
/*
 * Blanking delay line
 * Carries colour and both blanking bits through the same number of
 * pxl_cen steps and zeroes colour outside the active area
 */
`timescale 1ns/1ps

module blank_delay (
    input  logic             clk,
    input  logic             rst,
    input  logic             pxl_cen,
    input  logic             pre_lhbl,
    input  logic             pre_lvbl,
    input  colmix_pkg::rgb_t rgb_in,
    output logic             lhbl,
    output logic             lvbl,
    output colmix_pkg::rgb_t rgb
);
    import colmix_pkg::*;

    typedef struct packed {
        logic lhbl;
        logic lvbl;
        rgb_t rgb;
    } stage_t;

    logic [1:0] bl_pre;            // Matches the pixel input register
    logic [1:0] bl_mid;            // Matches the gated colour register
    stage_t     line [BLANK_DLY];

    always_ff @(posedge clk) begin
        if (rst) begin
            bl_pre <= '0;
            bl_mid <= '0;
            for (int i = 0; i < BLANK_DLY; i++) line[i] <= '0;
        end else if (pxl_cen) begin
            bl_pre  <= {pre_lhbl, pre_lvbl};
            bl_mid  <= bl_pre;
            line[0] <= {bl_mid, rgb_in};  // Colour joins blanking here
            for (int i = 1; i < BLANK_DLY; i++) line[i] <= line[i-1];
        end
    end

    assign lhbl = line[BLANK_DLY-1].lhbl;
    assign lvbl = line[BLANK_DLY-1].lvbl;
    assign rgb  = (lhbl && lvbl) ? line[BLANK_DLY-1].rgb : '0;  // Black borders

endmodule

//--- design/colmix_pixel.sv
/*
 * Pixel colour stage
 * Picks the palette address from the layer code, unpacks the returned
 * colour word, applies shadow dimming and blacks out when video is off
 */
`timescale 1ns/1ps

module colmix_pixel (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  video_en,
    input  colmix_pkg::pxl_in_t   pix,
    output colmix_pkg::pal_addr_t vid_addr,
    input  colmix_pkg::pal_word_t vid_rdata,
    output colmix_pkg::rgb_t      rgb_gated
);
    import colmix_pkg::*;

    pxl_in_t   pix_q;       // Pixel held for one pxl_cen period
    pal_addr_t rd_mux;      // Sprite/road address
    logic      shadow_rd;   // Shadow flag lined up with vid_rdata
    rgb_t      rgb_pal;     // Raw unpacked colour
    rgb_t      rgb_dim;
    rgb_t      rgb_next;

    // Channel minus a quarter of itself
    function automatic chan_t dim(input chan_t a);
        return a - (a >> 2);
    endfunction

    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pix_q <= pix;
        end
        shadow_rd <= pix_q.shadow;  // Same clock as the RAM read
    end

    // Layer rule for the palette address
    always_comb begin
        rd_mux[3:0] = pix_q.rd_pxl[3:0];
        case (pix_q.rc)
            2'd0, 2'd1: rd_mux[5:4] = 2'b11;
            2'd2:       rd_mux[5:4] = {1'b0, pix_q.rd_pxl[4]};
            default:    rd_mux[5:4] = pix_q.rd_pxl[5:4];
        endcase
        rd_mux[PAL_AW-1:6] = {(PAL_AW-6){pix_q.rc[1]}};  // Upper bank from layer
    end

    assign vid_addr = (pix_q.rc == 2'd3) ? pix_q.tmap_addr : rd_mux;  // Tile map

    // 4 MSBs then the spare LSB bit
    assign rgb_pal.red   = {vid_rdata[3:0],  vid_rdata[12]};
    assign rgb_pal.green = {vid_rdata[7:4],  vid_rdata[13]};
    assign rgb_pal.blue  = {vid_rdata[11:8], vid_rdata[14]};

    assign rgb_dim.red   = dim(rgb_pal.red);
    assign rgb_dim.green = dim(rgb_pal.green);
    assign rgb_dim.blue  = dim(rgb_pal.blue);

    always_comb begin
        rgb_next = (shadow_rd && !vid_rdata[15]) ? rgb_dim : rgb_pal;  // Bit 15 protects
        if (!video_en) begin
            rgb_next = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_gated <= '0;
        end else if (pxl_cen) begin
            rgb_gated <= rgb_next;
        end
    end

endmodule

//--- design/pal_apb.sv
/*
 * APB slave for the palette
 * Turns CPU transfers into palette RAM accesses. Writes finish in the
 * first access cycle, reads get one wait state for the RAM latency
 */
`timescale 1ns/1ps

module pal_apb (
    input  logic                  clk,
    input  logic                  rst,
    input  colmix_pkg::apb_req_t  apb_req,
    output colmix_pkg::apb_rsp_t  apb_rsp,
    // Palette RAM CPU port
    output colmix_pkg::pal_addr_t cpu_addr,
    output colmix_pkg::pal_word_t cpu_wdata,
    output logic [1:0]            cpu_we,
    input  colmix_pkg::pal_word_t cpu_rdata
);
    import colmix_pkg::*;

    apb_state_t state;
    logic       access;     // Access phase of any transfer
    logic       wr_access;

    assign access    = apb_req.psel & apb_req.penable;
    assign wr_access = access & apb_req.pwrite;

    // Word address, byte bit dropped
    assign cpu_addr  = apb_req.paddr[PAL_AW:1];
    assign cpu_wdata = apb_req.pwdata;
    assign cpu_we    = apb_req.pstrb & {2{wr_access}};  // No write outside access phase

    always_comb begin
        apb_rsp.prdata = cpu_rdata;  // Valid in the wait-state cycle
        // Writes ready at once, reads after the wait state
        apb_rsp.pready = wr_access | (access & (state == APB_RD_WAIT));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= APB_IDLE;
        end else begin
            case (state)
                APB_IDLE: begin
                    if (access && !apb_req.pwrite) begin
                        state <= APB_RD_WAIT;  // RAM read launched on this edge
                    end
                end
                APB_RD_WAIT: state <= APB_IDLE;  // Read completes here
                default:     state <= APB_IDLE;
            endcase
        end
    end

endmodule

//--- design/pal_ram.sv
/*
 * Palette RAM
 * 2048 x 16 dual-port memory. CPU port reads and writes with byte
 * enables, video port only reads. Both ports have one clock latency
 */
`timescale 1ns/1ps

module pal_ram (
    input  logic                  clk,
    // CPU side
    input  colmix_pkg::pal_addr_t cpu_addr,
    input  colmix_pkg::pal_word_t cpu_wdata,
    input  logic [1:0]            cpu_we,     // Byte enables
    output colmix_pkg::pal_word_t cpu_rdata,
    // Video side
    input  colmix_pkg::pal_addr_t vid_addr,
    output colmix_pkg::pal_word_t vid_rdata
);
    import colmix_pkg::*;

    pal_word_t mem [0:(1<<PAL_AW)-1];

    // CPU port reads return old data on a colliding write
    always_ff @(posedge clk) begin
        if (cpu_we[0]) begin
            mem[cpu_addr][7:0] <= cpu_wdata[7:0];
        end
        if (cpu_we[1]) begin
            mem[cpu_addr][15:8] <= cpu_wdata[15:8];
        end
        cpu_rdata <= mem[cpu_addr];
    end

    // Video port
    always_ff @(posedge clk) begin
        vid_rdata <= mem[vid_addr];  // Old word too if CPU writes same entry
    end

endmodule

//--- design/colmix_pkg.sv
/*
 * Colour mixer shared definitions
 * Palette, pixel, colour and APB types, plus the fixed widths and
 * the blanking delay used across the mixer
 */
package colmix_pkg;

    localparam int PAL_AW    = 11;  // 2048 palette words
    localparam int PAL_DW    = 16;
    localparam int CHAN_W    = 5;   // Per colour channel
    localparam int APB_AW    = 12;  // Byte address, bit 0 ignored
    localparam int BLANK_DLY = 2;   // Extra pxl_cen steps on colour and blanking

    typedef logic [PAL_AW-1:0] pal_addr_t;

    // Bits 3:0 R, 7:4 G, 11:8 B upper parts
    // Bits 12..14 the R/G/B LSBs, bit 15 shadow protect
    typedef logic [PAL_DW-1:0] pal_word_t;

    typedef logic [CHAN_W-1:0] chan_t;
    typedef logic [1:0]        layer_t;

    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } rgb_t;

    // Pixel as delivered by the tile and sprite side
    typedef struct packed {
        pal_addr_t  tmap_addr;  // Full address, used on layer 3
        logic [7:0] rd_pxl;     // Sprite or road pixel
        layer_t     rc;         // Layer code
        logic       shadow;
    } pxl_in_t;

    typedef struct packed {
        logic              psel;
        logic              penable;
        logic              pwrite;
        logic [APB_AW-1:0] paddr;
        logic [PAL_DW-1:0] pwdata;
        logic [1:0]        pstrb;   // Byte strobes
    } apb_req_t;

    typedef struct packed {
        logic [PAL_DW-1:0] prdata;
        logic              pready;
    } apb_rsp_t;

    typedef enum logic {
        APB_IDLE,
        APB_RD_WAIT     // Read address presented, data next cycle
    } apb_state_t;

endpackage
